// ==== common/cache_pkg.sv ====
package cache_pkg;

    // Address field widths
    localparam int tag_w      = 5;
    localparam int index_w    = 8;
    localparam int word_sel_w = 2;

    localparam int sets       = 256;
    localparam int line_words = 4;
    localparam int word_w     = 16;

    // Controller state codes
    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_compare = 3'd1;
    localparam logic [2:0] st_wb      = 3'd2;  // Victim write-back beats
    localparam logic [2:0] st_fill    = 3'd3;  // Line refill beats
    localparam logic [2:0] st_finish  = 3'd4;

    typedef logic [word_w-1:0] cache_word_t;

    typedef struct packed {
        logic [tag_w-1:0]      tag;
        logic [index_w-1:0]    index;
        logic [word_sel_w-1:0] word_sel;
        logic                  byte_sel;  // Ignored, word accesses only
    } cache_addr_fields_t;

    typedef union packed {
        logic [15:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_t;

endpackage

// ==== common/wb_pkg.sv ====
package wb_pkg;

    // Byte address on the bus, bit 0 always clear
    localparam int wb_adr_w = 16;

    localparam int wb_dat_w = 16;

    // One single-word classic cycle per beat
    localparam int beats_per_line = 4;

endpackage

// ==== cache/cache_way.sv ====
`timescale 1ns/1ns

module cache_way (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             en,
    input  logic                             wr,
    input  logic [cache_pkg::index_w-1:0]    index,
    input  logic [cache_pkg::tag_w-1:0]      tag_in,
    input  logic [cache_pkg::word_sel_w-1:0] word_sel,
    input  cache_pkg::cache_word_t           wdata,
    input  logic                             set_valid,
    input  logic                             set_dirty,
    output logic                             hit,
    output logic                             valid,
    output logic                             dirty,
    output logic [cache_pkg::tag_w-1:0]      tag_out,
    output cache_pkg::cache_word_t           rdata
);

    logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::sets];
    cache_pkg::cache_word_t      data_mem [cache_pkg::sets][cache_pkg::line_words];

    // Per-set status bits, cleared on reset
    logic [cache_pkg::sets-1:0] valid_q;
    logic [cache_pkg::sets-1:0] dirty_q;

    // Combinational lookup of the addressed set
    assign tag_out = tag_mem[index];
    assign valid   = valid_q[index];
    assign dirty   = dirty_q[index];
    assign rdata   = data_mem[index][word_sel];

    assign hit = en & valid_q[index] & (tag_mem[index] == tag_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr) begin
            valid_q[index] <= set_valid;
            dirty_q[index] <= set_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            tag_mem[index]            <= tag_in;
            data_mem[index][word_sel] <= wdata;  // One word per write
        end
    end

    // Controller only writes a way it has selected
    a_wr_needs_en : assert property (@(posedge clk) disable iff (rst) wr |-> en);

endmodule

// ==== cache/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    // Processor side
    input  cache_pkg::cache_addr_t             addr,
    input  cache_pkg::cache_word_t             wdata,
    input  logic                               rd,
    input  logic                               wr,
    output cache_pkg::cache_word_t             rdata,
    output logic                               done,
    output logic                               hit,
    // Wishbone master
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic                               wb_we,
    output logic [wb_pkg::wb_adr_w-1:0]        wb_adr,
    output logic [wb_pkg::wb_dat_w-1:0]        wb_dat_o,
    input  logic [wb_pkg::wb_dat_w-1:0]        wb_dat_i,
    input  logic                               wb_ack,
    // Controls shared by both ways
    output logic [cache_pkg::index_w-1:0]      way_index,
    output logic [cache_pkg::tag_w-1:0]        way_wtag,
    output logic [cache_pkg::word_sel_w-1:0]   way_word_sel,
    output cache_pkg::cache_word_t             way_wdata,
    output logic                               way_set_valid,
    output logic                               way_set_dirty,
    // Way 0
    output logic                               way_en_0,
    output logic                               way_wr_0,
    input  logic                               way_hit_0,
    input  logic                               way_valid_0,
    input  logic                               way_dirty_0,
    input  logic [cache_pkg::tag_w-1:0]        way_tag_0,
    input  cache_pkg::cache_word_t             way_rdata_0,
    // Way 1
    output logic                               way_en_1,
    output logic                               way_wr_1,
    input  logic                               way_hit_1,
    input  logic                               way_valid_1,
    input  logic                               way_dirty_1,
    input  logic [cache_pkg::tag_w-1:0]        way_tag_1,
    input  cache_pkg::cache_word_t             way_rdata_1
);

    logic [2:0]                          state_q;
    logic [cache_pkg::word_sel_w-1:0]    beat_q;
    logic                                victim_q;
    logic                                cyc_q;
    logic                                stb_q;
    logic [cache_pkg::sets-1:0]          lru_q;     // Points at the older way

    cache_pkg::cache_addr_t              bus_addr;
    logic                                any_hit;
    logic                                lru_vic;
    logic                                vic_dirty;
    logic                                rd_way;
    logic                                last_beat;
    logic                                beat_done;

    assign any_hit   = way_hit_0 | way_hit_1;
    assign lru_vic   = lru_q[addr.f.index];
    assign vic_dirty = lru_vic ? (way_valid_1 & way_dirty_1) : (way_valid_0 & way_dirty_0);
    assign last_beat = int'(beat_q) == wb_pkg::beats_per_line - 1;
    assign beat_done = stb_q & wb_ack;

    // Hit reads come from the hitting way, miss reads from the refilled victim
    assign rd_way = (state_q == cache_pkg::st_compare) ? way_hit_1 : victim_q;
    assign rdata  = rd_way ? way_rdata_1 : way_rdata_0;
    assign hit    = (state_q == cache_pkg::st_compare) & any_hit;
    assign done   = hit | (state_q == cache_pkg::st_finish);

    assign way_index = addr.f.index;
    assign way_wtag  = addr.f.tag;

    always_comb begin
        way_en_0      = 1'b0;
        way_en_1      = 1'b0;
        way_wr_0      = 1'b0;
        way_wr_1      = 1'b0;
        way_word_sel  = addr.f.word_sel;
        way_wdata     = wdata;
        way_set_valid = 1'b1;
        way_set_dirty = 1'b1;
        case (state_q)
            cache_pkg::st_compare: begin
                way_en_0 = 1'b1;
                way_en_1 = 1'b1;
                way_wr_0 = wr & way_hit_0;  // Write hit marks the line dirty
                way_wr_1 = wr & way_hit_1;
            end
            cache_pkg::st_wb: begin
                way_en_0     = ~victim_q;
                way_en_1     = victim_q;
                way_word_sel = beat_q;
            end
            cache_pkg::st_fill: begin
                way_en_0     = ~victim_q;
                way_en_1     = victim_q;
                way_wr_0     = ~victim_q & beat_done;
                way_wr_1     = victim_q & beat_done;
                way_word_sel = beat_q;
                // Write miss merges the processor word into the refill
                if (!(wr && beat_q == addr.f.word_sel)) begin
                    way_wdata = wb_dat_i;
                end
                way_set_valid = last_beat;  // Line becomes valid on the final beat
                way_set_dirty = wr;
            end
            cache_pkg::st_finish: begin
                way_en_0 = ~victim_q;
                way_en_1 = victim_q;
            end
            default: ;
        endcase
    end

    // Bus address reuses the request fields, victim tag during write-back
    always_comb begin
        bus_addr            = addr;
        bus_addr.f.word_sel = beat_q;
        bus_addr.f.byte_sel = 1'b0;
        if (state_q == cache_pkg::st_wb) begin
            bus_addr.f.tag = victim_q ? way_tag_1 : way_tag_0;
        end
    end

    assign wb_adr   = bus_addr.raw;
    assign wb_dat_o = victim_q ? way_rdata_1 : way_rdata_0;
    assign wb_cyc   = cyc_q;
    assign wb_stb   = stb_q;
    assign wb_we    = stb_q & (state_q == cache_pkg::st_wb);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= cache_pkg::st_idle;
            beat_q   <= '0;
            victim_q <= 1'b0;
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            lru_q    <= '0;
        end else begin
            case (state_q)
                cache_pkg::st_idle: begin
                    if (rd | wr) begin
                        state_q <= cache_pkg::st_compare;
                    end
                end
                cache_pkg::st_compare: begin
                    if (any_hit) begin
                        lru_q[addr.f.index] <= ~way_hit_1;
                        state_q             <= cache_pkg::st_idle;
                    end else begin
                        victim_q <= lru_vic;
                        beat_q   <= '0;
                        state_q  <= vic_dirty ? cache_pkg::st_wb : cache_pkg::st_fill;
                    end
                end
                cache_pkg::st_wb, cache_pkg::st_fill: begin
                    if (beat_done) begin
                        cyc_q  <= 1'b0;  // Drop for a cycle between words
                        stb_q  <= 1'b0;
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= (state_q == cache_pkg::st_wb) ?
                                       cache_pkg::st_fill : cache_pkg::st_finish;
                        end
                    end else if (!stb_q) begin
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                    end
                end
                cache_pkg::st_finish: begin
                    lru_q[addr.f.index] <= ~victim_q;  // Refilled way is now newest
                    state_q             <= cache_pkg::st_idle;
                end
                default: state_q <= cache_pkg::st_idle;
            endcase
        end
    end

    a_rd_wr_excl : assert property (@(posedge clk) disable iff (rst) !(rd && wr));

    a_stb_in_cyc : assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    // Slave may stall, address must hold until ack
    a_adr_stable : assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> $stable(wb_adr));

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ns

module cache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cache_addr_t       addr,
    input  cache_pkg::cache_word_t       wdata,
    input  logic                         rd,
    input  logic                         wr,
    output cache_pkg::cache_word_t       rdata,
    output logic                         done,
    output logic                         hit,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [wb_pkg::wb_adr_w-1:0]  wb_adr,
    output logic [wb_pkg::wb_dat_w-1:0]  wb_dat_o,
    input  logic [wb_pkg::wb_dat_w-1:0]  wb_dat_i,
    input  logic                         wb_ack
);

    logic [cache_pkg::index_w-1:0]    way_index;
    logic [cache_pkg::tag_w-1:0]      way_wtag;
    logic [cache_pkg::word_sel_w-1:0] way_word_sel;
    cache_pkg::cache_word_t           way_wdata;
    logic                             way_set_valid;
    logic                             way_set_dirty;

    logic                             way_en_0, way_wr_0, way_hit_0, way_valid_0, way_dirty_0;
    logic                             way_en_1, way_wr_1, way_hit_1, way_valid_1, way_dirty_1;
    logic [cache_pkg::tag_w-1:0]      way_tag_0, way_tag_1;
    cache_pkg::cache_word_t           way_rdata_0, way_rdata_1;

    cache_ctrl ctrl (
        .clk(clk), .rst(rst),
        .addr(addr), .wdata(wdata), .rd(rd), .wr(wr),
        .rdata(rdata), .done(done), .hit(hit),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .way_index(way_index), .way_wtag(way_wtag), .way_word_sel(way_word_sel),
        .way_wdata(way_wdata), .way_set_valid(way_set_valid), .way_set_dirty(way_set_dirty),
        .way_en_0(way_en_0), .way_wr_0(way_wr_0), .way_hit_0(way_hit_0),
        .way_valid_0(way_valid_0), .way_dirty_0(way_dirty_0),
        .way_tag_0(way_tag_0), .way_rdata_0(way_rdata_0),
        .way_en_1(way_en_1), .way_wr_1(way_wr_1), .way_hit_1(way_hit_1),
        .way_valid_1(way_valid_1), .way_dirty_1(way_dirty_1),
        .way_tag_1(way_tag_1), .way_rdata_1(way_rdata_1)
    );

    cache_way way0 (
        .clk(clk), .rst(rst), .en(way_en_0), .wr(way_wr_0),
        .index(way_index), .tag_in(way_wtag), .word_sel(way_word_sel), .wdata(way_wdata),
        .set_valid(way_set_valid), .set_dirty(way_set_dirty),
        .hit(way_hit_0), .valid(way_valid_0), .dirty(way_dirty_0),
        .tag_out(way_tag_0), .rdata(way_rdata_0)
    );

    cache_way way1 (
        .clk(clk), .rst(rst), .en(way_en_1), .wr(way_wr_1),
        .index(way_index), .tag_in(way_wtag), .word_sel(way_word_sel), .wdata(way_wdata),
        .set_valid(way_set_valid), .set_dirty(way_set_dirty),
        .hit(way_hit_1), .valid(way_valid_1), .dirty(way_dirty_1),
        .tag_out(way_tag_1), .rdata(way_rdata_1)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    localparam int half_period = 20;  // 40 ns period

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

// ==== sim/wb_mem_model.sv ====
`timescale 1ns/1ns

module wb_mem_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [wb_pkg::wb_adr_w-1:0] adr,
    input  logic [wb_pkg::wb_dat_w-1:0] wdat,
    output logic [wb_pkg::wb_dat_w-1:0] rdat,
    output logic                        ack
);

    localparam int          words    = 1 << (wb_pkg::wb_adr_w - 1);
    localparam logic [15:0] fill_key = 16'h5ac3;

    logic [wb_pkg::wb_dat_w-1:0] mem [words];
    logic [31:0]                 lfsr;
    logic                        waiting;
    logic [1:0]                  wait_cnt;
    logic [1:0]                  delay;
    logic                        go;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // Initial contents follow the word address
    initial begin
        ack  = 1'b0;
        rdat = '0;
        for (int i = 0; i < words; i++) begin
            mem[i] = 16'(i) ^ fill_key;
        end
    end

    always @(posedge clk) begin
        go = 1'b0;
        if (rst) begin
            ack      <= 1'b0;
            waiting  <= 1'b0;
            wait_cnt <= 2'd0;
            lfsr     = 32'h4cca_c4c1;
        end else if (ack) begin
            ack <= 1'b0;  // One ack per cycle
        end else if (cyc && stb) begin
            if (!waiting) begin
                // Two stepped bits give 0 to 3 extra cycles
                lfsr     = lfsr_step(lfsr);
                delay[0] = lfsr[0];
                lfsr     = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                if (delay == 2'd0) begin
                    go = 1'b1;
                end else begin
                    waiting  <= 1'b1;
                    wait_cnt <= delay - 2'd1;
                end
            end else if (wait_cnt == 2'd0) begin
                waiting <= 1'b0;
                go = 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (go) begin
                ack <= 1'b1;
                if (we) begin
                    mem[adr[15:1]] = wdat;  // Byte bit ignored
                end else begin
                    rdat <= mem[adr[15:1]];
                end
            end
        end
    end

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

    localparam logic [15:0] fill_key = 16'h5ac3;  // Memory model start pattern
    localparam int          max_wait = 200;

    logic                        clk;
    logic                        rst;
    cache_pkg::cache_addr_t      addr;
    cache_pkg::cache_word_t      wdata;
    logic                        rd;
    logic                        wr;
    cache_pkg::cache_word_t      rdata;
    logic                        done;
    logic                        hit;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic                        wb_ack;
    logic [wb_pkg::wb_adr_w-1:0] wb_adr;
    logic [wb_pkg::wb_dat_w-1:0] wb_dat_o;
    logic [wb_pkg::wb_dat_w-1:0] wb_dat_i;

    // Stimulus table with one entry per index across the queues
    string                  step_name [$];
    logic                   step_wr [$];
    cache_pkg::cache_addr_t step_addr [$];
    cache_pkg::cache_word_t step_wdata [$];
    logic                   step_chk [$];  // Hit flag known in advance
    logic                   step_hit [$];

    cache_pkg::cache_word_t shadow [int];  // Last written value per word address
    logic [31:0]            rng;
    int                     errors;
    int                     checks;
    int                     step_errs;
    int                     bus_beats;
    int                     beats_at_done;
    logic                   timed_out;

    tb_clock clkgen (.clk(clk));

    wb_mem_model mem (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
        .adr(wb_adr), .wdat(wb_dat_o), .rdat(wb_dat_i), .ack(wb_ack)
    );

    cache_top UUT (
        .clk(clk), .rst(rst), .addr(addr), .wdata(wdata), .rd(rd), .wr(wr),
        .rdata(rdata), .done(done), .hit(hit),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always @(posedge clk) begin
        if (rst) begin
            bus_beats <= 0;
        end else if (wb_cyc && wb_stb && wb_ack) begin
            bus_beats <= bus_beats + 1;  // Completed single-word cycles
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v   = {v[14:0], rng[0]};
            rng = lfsr_step(rng);
        end
    endtask

    function automatic cache_pkg::cache_addr_t make_addr(
        input logic [cache_pkg::tag_w-1:0]      tag,
        input logic [cache_pkg::index_w-1:0]    index,
        input logic [cache_pkg::word_sel_w-1:0] word
    );
        cache_pkg::cache_addr_t a;
        a.raw        = '0;
        a.f.tag      = tag;
        a.f.index    = index;
        a.f.word_sel = word;
        return a;
    endfunction

    task automatic add_step(input string name, input logic is_wr,
                            input cache_pkg::cache_addr_t a, input cache_pkg::cache_word_t d,
                            input logic chk, input logic exp_hit);
        step_name.push_back(name);
        step_wr.push_back(is_wr);
        step_addr.push_back(a);
        step_wdata.push_back(d);
        step_chk.push_back(chk);
        step_hit.push_back(exp_hit);
    endtask

    // Transparent cache returns the last write or else the memory pattern
    function automatic cache_pkg::cache_word_t expected_word(input cache_pkg::cache_addr_t a);
        int wa;
        wa = int'(a.raw[15:1]);
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return {1'b0, a.raw[15:1]} ^ fill_key;
    endfunction

    task automatic check_word(input string name, input cache_pkg::cache_word_t exp,
                              input cache_pkg::cache_word_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
            step_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
            step_errs++;
        end
    endtask

    task automatic wait_done(input string name, output logic ok);
        int n;
        n = 0;
        while (done !== 1'b1 && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        ok = (done === 1'b1);
        if (!ok) begin
            $display("Timeout: no done within %0d cycles in %s", max_wait, name);
        end
    endtask

    task automatic build_table();
        logic [15:0]            b;
        logic [15:0]            d;
        logic                   op;
        cache_pkg::cache_addr_t a;
        add_step("first_read", 1'b0, make_addr(5'd3, 8'h10, 2'd0), '0, 1'b1, 1'b0);
        add_step("fill_word1", 1'b0, make_addr(5'd3, 8'h10, 2'd1), '0, 1'b1, 1'b1);
        add_step("fill_word2", 1'b0, make_addr(5'd3, 8'h10, 2'd2), '0, 1'b1, 1'b1);
        add_step("fill_word3", 1'b0, make_addr(5'd3, 8'h10, 2'd3), '0, 1'b1, 1'b1);
        add_step("fill_word0", 1'b0, make_addr(5'd3, 8'h10, 2'd0), '0, 1'b1, 1'b1);
        add_step("write_hit", 1'b1, make_addr(5'd3, 8'h10, 2'd2), 16'hbeef, 1'b1, 1'b1);
        add_step("read_back", 1'b0, make_addr(5'd3, 8'h10, 2'd2), '0, 1'b1, 1'b1);
        add_step("write_miss", 1'b1, make_addr(5'd7, 8'h20, 2'd1), 16'h1234, 1'b1, 1'b0);
        add_step("alloc_word3", 1'b0, make_addr(5'd7, 8'h20, 2'd3), '0, 1'b1, 1'b1);
        add_step("alloc_word1", 1'b0, make_addr(5'd7, 8'h20, 2'd1), '0, 1'b1, 1'b1);
        // Dirty line in way 0 of set 0x30 is pushed out by tag 4
        add_step("evict_write", 1'b1, make_addr(5'd1, 8'h30, 2'd0), 16'ha5a5, 1'b1, 1'b0);
        add_step("evict_fill", 1'b0, make_addr(5'd2, 8'h30, 2'd0), '0, 1'b1, 1'b0);
        add_step("evict_dirty", 1'b0, make_addr(5'd4, 8'h30, 2'd0), '0, 1'b1, 1'b0);
        add_step("evict_touch", 1'b0, make_addr(5'd2, 8'h30, 2'd1), '0, 1'b1, 1'b1);
        add_step("evict_reread", 1'b0, make_addr(5'd1, 8'h30, 2'd0), '0, 1'b1, 1'b0);
        add_step("evict_keep", 1'b0, make_addr(5'd2, 8'h30, 2'd0), '0, 1'b1, 1'b1);
        // Random mix of four tags on sets 0x40 and 0x41
        for (int i = 0; i < 24; i++) begin
            a.raw = '0;
            take_bits(2, b);
            a.f.tag = {3'b010, b[1:0]};
            take_bits(1, b);
            a.f.index = {7'h20, b[0]};
            take_bits(2, b);
            a.f.word_sel = b[1:0];
            take_bits(1, b);
            op = b[0];
            take_bits(16, d);
            add_step($sformatf("random_%0d", i), op, a, d, 1'b0, 1'b0);
        end
    endtask

    task automatic run_step(input int k);
        logic                   ok;
        cache_pkg::cache_addr_t a;
        cache_pkg::cache_word_t exp;
        step_errs = 0;
        a   = step_addr[k];
        exp = expected_word(a);
        @(posedge clk);
        addr  <= a;
        wdata <= step_wdata[k];
        rd    <= ~step_wr[k];
        wr    <= step_wr[k];
        @(negedge clk);
        wait_done(step_name[k], ok);
        if (!ok) begin
            timed_out = 1'b1;
            errors++;
        end else begin
            if (step_chk[k]) begin
                check_bit({step_name[k], " hit"}, step_hit[k], hit);
                if (step_hit[k]) begin
                    // No bus cycle since the previous request finished
                    check_bit({step_name[k], " bus"}, 1'b0, bus_beats != beats_at_done);
                end
            end
            beats_at_done = bus_beats;
            if (step_wr[k]) begin
                shadow[int'(a.raw[15:1])] = step_wdata[k];
            end else begin
                check_word({step_name[k], " data"}, exp, rdata);
            end
            $display("%s: %s", step_name[k], (step_errs == 0) ? "ok" : "mismatch");
        end
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    initial begin
        rst           <= 1'b1;
        addr          <= '0;
        wdata         <= '0;
        rd            <= 1'b0;
        wr            <= 1'b0;
        rng           = 32'h4cca_c4c1;
        errors        = 0;
        checks        = 0;
        step_errs     = 0;
        beats_at_done = 0;
        timed_out     = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("reset done", 1'b0, done);
        check_bit("reset hit", 1'b0, hit);
        check_bit("reset wb_cyc", 1'b0, wb_cyc);
        check_bit("reset wb_stb", 1'b0, wb_stb);
        check_bit("reset wb_we", 1'b0, wb_we);
        $display("reset_outputs: %s", (step_errs == 0) ? "ok" : "mismatch");
        build_table();
        for (int k = 0; k < step_name.size() && !timed_out; k++) begin
            run_step(k);
        end
        $display("%0d tests, %0d checks, %0d errors", step_name.size() + 1, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/cache_pkg.sv
common/wb_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
verilog/cache_top.sv
sim/tb_clock.sv
sim/wb_mem_model.sv
sim/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
